// File: filelist.f
mpr121_pkg.sv
mpr121_host_port.sv
mpr121_sequencer.sv
i2c_byte_engine.sv
mpr121_controller.sv
tb_mpr121_target.sv
tb_mpr121_controller.sv

// File: i2c_byte_engine.sv
`timescale 1ns/100ps

module i2c_byte_engine import mpr121_pkg::*; #(
	parameter int P_PRESCALE = 125 // quarter SCL period in clocks
) (
	input  logic      i_CLK,
	input  logic      i_RSTN,
	input  byte_cmd_t i_cmd,
	input  logic      i_sda,    // resolved bus level
	output byte_rsp_t o_rsp,
	output logic      o_scl_oe, // 1 pulls SCL low
	output logic      o_sda_oe  // 1 pulls SDA low
);

	localparam int            PW         = (P_PRESCALE > 1) ? $clog2(P_PRESCALE) : 1;
	localparam logic [PW-1:0] PRESC_LAST = PW'(P_PRESCALE - 1);

	logic          busy;
	byte_op_e      op_r;
	logic          ack_out_r;
	logic [PW-1:0] presc;    // cycles within a quarter
	logic [1:0]    phase;    // quarter within a bit
	logic [3:0]    bit_cnt;  // 0..7 data, 8 ack
	reg_byte_t     shift;
	logic          sda_smp;  // SDA taken mid SCL high
	logic          q_first;
	logic          q_last;
	logic          is_byte;
	logic          bit_oe;   // SDA drive for the current bit

	assign q_first = (presc == '0);
	assign q_last  = (presc == PRESC_LAST);
	assign is_byte = (op_r == op_write) || (op_r == op_read);

	always_comb
	begin
		if (bit_cnt == 4'd8)
			bit_oe = (op_r == op_read) ? !ack_out_r : 1'b0; // our ack, or release for target
		else
			bit_oe = (op_r == op_write) ? !shift[7] : 1'b0; // msb first
	end

	// datapath, shift in on every bit, read or write
	always_ff @(posedge i_CLK)
	begin
		if (!busy && i_cmd.stb)
		begin
			op_r      <= i_cmd.op;
			ack_out_r <= i_cmd.ack_out;
			shift     <= i_cmd.frame.raw;
		end
		else if (busy)
		begin
			if (phase == 2'd2 && q_first)
				sda_smp <= i_sda;
			if (phase == 2'd3 && q_last && bit_cnt < 4'd8)
				shift <= {shift[6:0], sda_smp};
		end
	end

	// ====================================================================
	// quarter sequencing and line control
	// ====================================================================
	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			busy     <= 1'b0;
			presc    <= '0;
			phase    <= 2'd0;
			bit_cnt  <= 4'd0;
			o_scl_oe <= 1'b0;
			o_sda_oe <= 1'b0;
			o_rsp    <= '0;
		end
		else
		begin
			o_rsp.done <= 1'b0;
			if (!busy)
			begin
				if (i_cmd.stb)
				begin
					busy    <= 1'b1;
					presc   <= '0;
					phase   <= 2'd0;
					bit_cnt <= 4'd0;
				end
			end
			else
			begin
				// line changes at the first cycle of each quarter
				if (q_first)
				begin
					case (op_r)
						op_start:
							case (phase)
								2'd0: o_sda_oe <= 1'b0; // release, SCL may be low
								2'd1: o_scl_oe <= 1'b0;
								2'd2: o_sda_oe <= 1'b1; // SDA falls, SCL high
								default: o_scl_oe <= 1'b1;
							endcase
						op_stop:
							case (phase)
								2'd0:
								begin
									o_scl_oe <= 1'b1;
									o_sda_oe <= 1'b1;
								end
								2'd1: o_scl_oe <= 1'b0;
								2'd2: o_sda_oe <= 1'b0; // SDA rises, SCL high
								default: o_sda_oe <= 1'b0; // hold idle
							endcase
						default: // write or read bit
							case (phase)
								2'd0: o_sda_oe <= bit_oe; // SCL low here
								2'd1: o_scl_oe <= 1'b0;
								2'd2: o_scl_oe <= 1'b0; // sample slot
								default: o_scl_oe <= 1'b1;
							endcase
					endcase
				end

				if (q_last)
				begin
					presc <= '0;
					phase <= phase + 2'd1;
					if (phase == 2'd3)
					begin
						if (!is_byte || bit_cnt == 4'd8)
						begin
							busy          <= 1'b0;
							o_rsp.done    <= 1'b1;
							o_rsp.rd_byte <= shift;
							o_rsp.nack    <= (op_r == op_write) && sda_smp;
						end
						else
							bit_cnt <= bit_cnt + 4'd1;
					end
				end
				else
					presc <= presc + 1'b1;
			end
		end
	end

	// sequencer waits for done before the next command
	a_no_cmd_busy : assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		i_cmd.stb |-> !busy);

	// inside a byte, SDA only moves while SCL is held low
	a_sda_scl_low : assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(busy && is_byte && $changed(o_sda_oe)) |-> o_scl_oe);

endmodule

// File: mpr121_controller.sv
`timescale 1ns/100ps

module mpr121_controller import mpr121_pkg::*; #(
	parameter int         P_PRESCALE    = 125,        // 100 kHz from 50 MHz
	parameter logic [6:0] P_TARGET_ADDR = MPR121_ADDR
) (
	input  logic      i_CLK,
	input  logic      i_RSTN,
	input  logic      i_write_en,
	input  logic      i_read_en,
	input  reg_byte_t i_reg_addr,
	input  reg_byte_t i_wr_data,
	input  logic      i_i2c_sda,    // resolved SDA
	output reg_byte_t o_rd_data,
	output logic      o_busy,
	output logic      o_fail,
	output logic      o_init_set,
	output logic      o_i2c_scl_oe, // open drain, 1 = low
	output logic      o_i2c_sda_oe
);

	host_req_t req;
	logic      req_stb;
	seq_done_t seq_done;
	byte_cmd_t cmd;
	byte_rsp_t rsp;

	// ====================================================================
	// host side -> sequencer -> bus side
	// ====================================================================
	mpr121_host_port i_host_port (
		.i_CLK      (i_CLK),
		.i_RSTN     (i_RSTN),
		.i_write_en (i_write_en),
		.i_read_en  (i_read_en),
		.i_reg_addr (i_reg_addr),
		.i_wr_data  (i_wr_data),
		.i_done     (seq_done),
		.o_req      (req),
		.o_req_stb  (req_stb),
		.o_rd_data  (o_rd_data),
		.o_busy     (o_busy),
		.o_fail     (o_fail),
		.o_init_set (o_init_set)
	);

	mpr121_sequencer #(.P_TARGET_ADDR(P_TARGET_ADDR)) i_sequencer (
		.i_CLK     (i_CLK),
		.i_RSTN    (i_RSTN),
		.i_req     (req),
		.i_req_stb (req_stb),
		.i_rsp     (rsp),
		.o_cmd     (cmd),
		.o_done    (seq_done)
	);

	i2c_byte_engine #(.P_PRESCALE(P_PRESCALE)) i_byte_engine (
		.i_CLK    (i_CLK),
		.i_RSTN   (i_RSTN),
		.i_cmd    (cmd),
		.i_sda    (i_i2c_sda),
		.o_rsp    (rsp),
		.o_scl_oe (o_i2c_scl_oe),
		.o_sda_oe (o_i2c_sda_oe)
	);

endmodule

// File: mpr121_host_port.sv
`timescale 1ns/100ps

module mpr121_host_port import mpr121_pkg::*; (
	input  logic      i_CLK,
	input  logic      i_RSTN,
	input  logic      i_write_en,  // level
	input  logic      i_read_en,   // level
	input  reg_byte_t i_reg_addr,
	input  reg_byte_t i_wr_data,
	input  seq_done_t i_done,      // completion from sequencer
	output host_req_t o_req,
	output logic      o_req_stb,
	output reg_byte_t o_rd_data,
	output logic      o_busy,
	output logic      o_fail,
	output logic      o_init_set
);

	logic armed;  // cleared on accept, set again once both enables drop
	logic accept;

	// write wins when both enables are high
	assign accept = o_init_set && !o_busy && armed && (i_write_en || i_read_en);

	// request payload
	always_ff @(posedge i_CLK)
	begin
		if (accept)
			o_req <= '{op_read: !i_write_en, reg_addr: i_reg_addr, wr_data: i_wr_data};
	end

	// ====================================================================
	// status flags
	// ====================================================================
	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			armed      <= 1'b1;
			o_req_stb  <= 1'b0;
			o_busy     <= 1'b0;
			o_fail     <= 1'b0;
			o_init_set <= 1'b0;
			o_rd_data  <= '0;
		end
		else
		begin
			o_req_stb <= accept; // one cycle
			if (accept)
			begin
				o_busy <= 1'b1;
				armed  <= 1'b0;
			end
			else if (!armed && !i_write_en && !i_read_en)
				armed <= 1'b1;    // enables seen low, ready for next

			if (i_done.done)
			begin
				o_fail <= i_done.nack;
				if (i_done.was_init)
					o_init_set <= 1'b1;
				else
				begin
					o_busy <= 1'b0;
					if (o_req.op_read && !i_done.nack)
						o_rd_data <= i_done.rd_data; // only good reads update
				end
			end
		end
	end

	// host completions only come back for an accepted request
	a_done_busy : assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(i_done.done && !i_done.was_init) |-> o_busy);

endmodule

// File: mpr121_pkg.sv
package mpr121_pkg;

	// ====================================================================
	// bus constants
	// ====================================================================
	localparam logic [6:0] MPR121_ADDR    = 7'h5A; // ADDR pin tied to ground
	localparam logic [7:0] SOFT_RESET_REG = 8'h80; // soft reset register
	localparam logic [7:0] SOFT_RESET_VAL = 8'h63; // magic value for soft reset

	// one register address or data byte
	typedef logic [7:0] reg_byte_t;

	// host request, latched by the host port
	typedef struct packed {
		logic      op_read;  // 1 read, 0 write
		reg_byte_t reg_addr; // target register
		reg_byte_t wr_data;  // data for a write
	} host_req_t;

	// byte engine actions
	typedef enum logic [1:0] {
		op_start = 2'd0, // start or repeated start
		op_write = 2'd1, // shift out 8 bits, sample ack
		op_read  = 2'd2, // shift in 8 bits, drive ack
		op_stop  = 2'd3
	} byte_op_e;

	// one bus word seen two ways
	// the engine only ever looks at raw
	typedef union packed {
		struct packed {
			logic [6:0] addr; // 7-bit target address
			logic       rw;   // 0 write, 1 read
		} adr;
		reg_byte_t raw;       // register address or data byte
	} i2c_frame_u;

	// sequencer -> engine
	typedef struct packed {
		logic       stb;     // one-cycle strobe
		byte_op_e   op;
		i2c_frame_u frame;   // byte to send
		logic       ack_out; // ack level after a read byte, 1 = NACK
	} byte_cmd_t;

	// engine -> sequencer
	typedef struct packed {
		logic      done;    // one-cycle pulse at end of action
		reg_byte_t rd_byte; // byte shifted in
		logic      nack;    // ack bit seen after a written byte
	} byte_rsp_t;

	// sequencer -> host port
	typedef struct packed {
		logic      done;     // one-cycle pulse
		logic      was_init; // soft reset sequence, not a host request
		logic      nack;     // missed ack somewhere
		reg_byte_t rd_data;
	} seq_done_t;

endpackage

// File: mpr121_sequencer.sv
`timescale 1ns/100ps

module mpr121_sequencer import mpr121_pkg::*; #(
	parameter logic [6:0] P_TARGET_ADDR = MPR121_ADDR
) (
	input  logic      i_CLK,
	input  logic      i_RSTN,
	input  host_req_t i_req,
	input  logic      i_req_stb,
	input  byte_rsp_t i_rsp,
	output byte_cmd_t o_cmd,
	output seq_done_t o_done
);

	localparam logic RW_WRITE = 1'b0;
	localparam logic RW_READ  = 1'b1;

	// one-hot, one state per pending byte action
	typedef enum logic [8:0] {
		st_idle    = 9'b000000001,
		st_start   = 9'b000000010, // start issued
		st_addr_w  = 9'b000000100, // address + W issued
		st_reg     = 9'b000001000, // register byte issued
		st_data    = 9'b000010000, // write data issued
		st_rstart  = 9'b000100000, // repeated start issued
		st_addr_r  = 9'b001000000, // address + R issued
		st_read    = 9'b010000000, // read byte with NACK issued
		st_stop    = 9'b100000000  // stop issued
	} seq_state_e;

	seq_state_e state;
	host_req_t  cur_req;
	reg_byte_t  rd_byte_r;
	logic       init_pend;  // soft reset still to do
	logic       is_init;
	logic       nack_r;
	logic       start_init;
	logic       start_host;

	function automatic byte_cmd_t mk_cmd(byte_op_e op, i2c_frame_u frame, logic ack);
		byte_cmd_t c;
		c.stb     = 1'b1;
		c.op      = op;
		c.frame   = frame;
		c.ack_out = ack;
		return c;
	endfunction

	function automatic i2c_frame_u addr_frame(logic rw);
		i2c_frame_u f;
		f.adr.addr = P_TARGET_ADDR;
		f.adr.rw   = rw;
		return f;
	endfunction

	function automatic i2c_frame_u data_frame(reg_byte_t b);
		i2c_frame_u f;
		f.raw = b;
		return f;
	endfunction

	assign start_init = (state == st_idle) && init_pend;
	assign start_host = (state == st_idle) && !init_pend && i_req_stb;

	// request and read byte, no reset needed
	always_ff @(posedge i_CLK)
	begin
		if (start_init)
			cur_req <= '{op_read: 1'b0, reg_addr: SOFT_RESET_REG, wr_data: SOFT_RESET_VAL};
		else if (start_host)
			cur_req <= i_req;
		if (state == st_read && i_rsp.done)
			rd_byte_r <= i_rsp.rd_byte;
	end

	// ====================================================================
	// byte command chain
	// ====================================================================
	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			state     <= st_idle;
			init_pend <= 1'b1;
			is_init   <= 1'b0;
			nack_r    <= 1'b0;
			o_cmd     <= '0;
			o_done    <= '0;
		end
		else
		begin
			o_cmd.stb   <= 1'b0;
			o_done.done <= 1'b0;
			case (state)
				st_idle:
					if (start_init || start_host)
					begin
						is_init   <= start_init;
						init_pend <= 1'b0;
						nack_r    <= 1'b0;
						o_cmd     <= mk_cmd(op_start, data_frame(8'h00), 1'b0);
						state     <= st_start;
					end
				st_start:
					if (i_rsp.done)
					begin
						o_cmd <= mk_cmd(op_write, addr_frame(RW_WRITE), 1'b0);
						state <= st_addr_w;
					end
				st_addr_w, st_reg, st_addr_r:
					if (i_rsp.done && i_rsp.nack)
					begin
						nack_r <= 1'b1; // abort straight to stop
						o_cmd  <= mk_cmd(op_stop, data_frame(8'h00), 1'b0);
						state  <= st_stop;
					end
					else if (i_rsp.done && state == st_addr_w)
					begin
						o_cmd <= mk_cmd(op_write, data_frame(cur_req.reg_addr), 1'b0);
						state <= st_reg;
					end
					else if (i_rsp.done && state == st_reg && cur_req.op_read)
					begin
						o_cmd <= mk_cmd(op_start, data_frame(8'h00), 1'b0); // repeated start
						state <= st_rstart;
					end
					else if (i_rsp.done && state == st_reg)
					begin
						o_cmd <= mk_cmd(op_write, data_frame(cur_req.wr_data), 1'b0);
						state <= st_data;
					end
					else if (i_rsp.done)
					begin
						o_cmd <= mk_cmd(op_read, data_frame(8'h00), 1'b1); // single byte, NACK
						state <= st_read;
					end
				st_rstart:
					if (i_rsp.done)
					begin
						o_cmd <= mk_cmd(op_write, addr_frame(RW_READ), 1'b0);
						state <= st_addr_r;
					end
				st_data, st_read:
					if (i_rsp.done)
					begin
						if (state == st_data)
							nack_r <= i_rsp.nack; // last written byte
						o_cmd <= mk_cmd(op_stop, data_frame(8'h00), 1'b0);
						state <= st_stop;
					end
				st_stop:
					if (i_rsp.done)
					begin
						o_done <= '{done: 1'b1, was_init: is_init, nack: nack_r, rd_data: rd_byte_r};
						state  <= st_idle;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

	// host port must wait for the previous completion
	a_req_idle : assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		i_req_stb |-> (state == st_idle && !init_pend));

	a_state_onehot : assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		$onehot(state));

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mpr121 controller testbench with verilator
set -e
cd "$(dirname "$0")"

TOP=tb_mpr121_controller
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -f filelist.f -o "V$TOP"

"./obj_dir/V$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
	echo "run_sim: testbench reported failure, see $LOG"
	exit 1
fi
grep -q "Simulation finished: PASS" "$LOG"

// File: tb_mpr121_controller.sv
`timescale 1ns/100ps

module tb_mpr121_controller import mpr121_pkg::*; ();

	localparam int PRESCALE    = 4;
	localparam int N_RAND      = 40;                  // random ops
	localparam int N_DIR       = 7;                   // directed ops
	localparam int N_XFERS     = 1 + N_RAND + N_DIR;  // init included
	localparam int TIMEOUT_CYC = N_XFERS * 40 * (4 * PRESCALE) * 2;

	logic        i_CLK;
	logic        i_RSTN;
	logic        i_write_en;
	logic        i_read_en;
	reg_byte_t   i_reg_addr;
	reg_byte_t   i_wr_data;
	reg_byte_t   o_rd_data;
	logic        o_busy;
	logic        o_fail;
	logic        o_init_set;
	logic        scl_oe;
	logic        sda_oe;
	logic        tgt_sda_oe;
	logic        scl;
	logic        sda;
	reg_byte_t   ref_mem [0:255]; // reference register array
	reg_byte_t   exp_rd;          // last good read
	logic [31:0] seed;
	int          cyc;

	assign scl = !scl_oe;                 // wired-AND, no stretching
	assign sda = !(sda_oe | tgt_sda_oe);

	mpr121_controller #(.P_PRESCALE(PRESCALE), .P_TARGET_ADDR(MPR121_ADDR)) i_mpr121_controller (
		.i_CLK(i_CLK), .i_RSTN(i_RSTN), .i_write_en(i_write_en), .i_read_en(i_read_en),
		.i_reg_addr(i_reg_addr), .i_wr_data(i_wr_data), .i_i2c_sda(sda),
		.o_rd_data(o_rd_data), .o_busy(o_busy), .o_fail(o_fail), .o_init_set(o_init_set),
		.o_i2c_scl_oe(scl_oe), .o_i2c_sda_oe(sda_oe)
	);

	tb_mpr121_target #(.P_ADDR(MPR121_ADDR)) i_target (.i_scl(scl), .i_sda(sda), .o_sda_oe(tgt_sda_oe));

	always #5 i_CLK = ~i_CLK;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input reg_byte_t act, input reg_byte_t exp);
		if (act !== exp)
			abort_run($sformatf("Mismatch at %0t: %s = %h, expected %h", $time, name, act, exp));
	endtask

	task automatic check_flag(input string name, input logic act, input logic exp);
		if (act !== exp)
			abort_run($sformatf("Mismatch at %0t: %s = %b, expected %b", $time, name, act, exp));
	endtask

	// ====================================================================
	// one host request, hold = cycles the enables stay up after done
	// ====================================================================
	task automatic run_xfer(input logic wr, input logic rd, input reg_byte_t adr,
		input reg_byte_t dat, input int hold);
		int   stops;
		int   wrs;
		logic exp_fail;
		stops = i_target.stop_cnt;
		wrs   = i_target.wr_cnt;
		@(negedge i_CLK);
		i_write_en = wr;
		i_read_en  = rd;
		i_reg_addr = adr;
		i_wr_data  = dat;
		do @(negedge i_CLK); while (!o_busy);
		if (hold == 0)
			{i_write_en, i_read_en} = 2'b00;
		do @(negedge i_CLK); while (o_busy);
		exp_fail = (adr == 8'hFF);       // target NACKs this register
		if (!exp_fail && wr)
			ref_mem[adr] = dat;            // write wins over read
		else if (!exp_fail && rd)
			exp_rd = ref_mem[adr];
		check_flag("o_fail", o_fail, exp_fail);
		check_byte("o_rd_data", o_rd_data, exp_rd);
		repeat (hold)
		begin
			@(negedge i_CLK);
			check_flag("o_busy", o_busy, 1'b0); // held enable must not restart
		end
		{i_write_en, i_read_en} = 2'b00;
		if (i_target.stop_cnt != stops + 1)
			abort_run($sformatf("target saw %0d transactions for one request",
				i_target.stop_cnt - stops));
		if (exp_fail && i_target.wr_cnt != wrs)
			abort_run("target register written during a NACKed request");
	endtask

	always @(posedge i_CLK)
	begin
		cyc = cyc + 1;
		if (cyc >= TIMEOUT_CYC)
			abort_run($sformatf("timeout after %0d cycles, DUT never finished", cyc));
	end

	initial
	begin
		i_CLK  = 1'b0;
		i_RSTN = 1'b0;
		{i_write_en, i_read_en, i_reg_addr, i_wr_data} = '0;
		seed   = 32'hf5aeb7f8;
		exp_rd = 8'h00;
		cyc    = 0;
		for (int i = 0; i < 256; i++)
			ref_mem[i] = 8'(i) ^ 8'hA5;  // same power-up content as the target
		repeat (3) @(posedge i_CLK);
		@(negedge i_CLK);
		i_RSTN = 1'b1;
		check_flag("o_init_set", o_init_set, 1'b0);
		check_flag("o_busy", o_busy, 1'b0);
		check_flag("o_fail", o_fail, 1'b0);
		check_byte("o_rd_data", o_rd_data, 8'h00);
		do @(negedge i_CLK); while (!o_init_set); // soft reset write
		ref_mem[SOFT_RESET_REG] = SOFT_RESET_VAL;
		check_byte("target reg 80", i_target.mem[SOFT_RESET_REG], SOFT_RESET_VAL);
		check_flag("o_fail", o_fail, 1'b0);

		// random ops over a small register window so reads hit writes
		for (int n = 0; n < N_RAND; n++)
		begin
			seed = lcg_step(seed);
			run_xfer(!seed[31], seed[31], {3'b000, seed[20:16]}, seed[15:8], 0);
		end

		// NACK on 8'hFF, then recovery
		seed = lcg_step(seed);
		run_xfer(1'b1, 1'b0, 8'hFF, seed[15:8], 0);
		run_xfer(1'b1, 1'b0, {3'b000, seed[20:16]}, seed[7:0], 0);
		run_xfer(1'b0, 1'b1, 8'hFF, 8'h00, 0);
		run_xfer(1'b0, 1'b1, {3'b000, seed[20:16]}, 8'h00, 0);

		// held enable, then both enables together
		seed = lcg_step(seed);
		run_xfer(1'b0, 1'b1, {3'b000, seed[12:8]}, 8'h00, 8 * 4 * PRESCALE);
		run_xfer(1'b1, 1'b1, {3'b000, seed[20:16]}, seed[7:0], 0);
		run_xfer(1'b0, 1'b1, {3'b000, seed[20:16]}, 8'h00, 0);

		for (int i = 0; i < 256; i++)
			check_byte($sformatf("target reg %02h", 8'(i)), i_target.mem[i], ref_mem[i]);
		if (i_target.err_cnt != 0)
			abort_run("target model saw a foreign address on the bus");
		else
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

// File: tb_mpr121_target.sv
`timescale 1ns/100ps

module tb_mpr121_target import mpr121_pkg::*; #(
	parameter logic [6:0] P_ADDR = MPR121_ADDR
) (
	input  logic i_scl,    // resolved SCL
	input  logic i_sda,    // resolved SDA
	output logic o_sda_oe  // 1 pulls SDA low
);

	reg_byte_t mem [0:255]; // register file
	reg_byte_t sh;          // byte shifted in
	reg_byte_t tx;          // byte going out on a read
	reg_byte_t ptr;         // register pointer
	int        bit_n;       // bits of current byte
	int        byte_n;      // bytes since start
	int        stop_cnt;    // finished transactions
	int        wr_cnt;      // data bytes stored
	int        err_cnt;     // foreign addresses seen
	logic      active;
	logic      reading;     // address byte had R
	logic      ignore;      // NACKed, wait for stop
	logic      ack_slot;    // ninth clock of a byte
	logic      scl_q;
	logic      sda_q;

	initial
	begin
		for (int i = 0; i < 256; i++)
			mem[i] = 8'(i) ^ 8'hA5; // power-up content
		{stop_cnt, wr_cnt, err_cnt, bit_n, byte_n} = '0;
		{active, reading, ignore, ack_slot, o_sda_oe} = '0;
		{sh, tx, ptr} = '0;
		scl_q = 1'b1;
		sda_q = 1'b1;
	end

	// ====================================================================
	// byte decode at the end of eight bits
	// ====================================================================
	task take_byte;
		if (byte_n == 0 && sh[7:1] == P_ADDR)
		begin
			reading  = sh[0];
			tx       = mem[ptr];
			o_sda_oe = 1'b1;  // ack own address
		end
		else if (byte_n == 0)
		begin
			ignore  = 1'b1;   // not us
			err_cnt = err_cnt + 1;
		end
		else if (byte_n == 1 && sh == 8'hFF)
			ignore = 1'b1;    // NACK rule, rest of frame dropped
		else if (byte_n == 1)
		begin
			ptr      = sh;
			o_sda_oe = 1'b1;
		end
		else
		begin
			mem[ptr] = sh;
			wr_cnt   = wr_cnt + 1;
			o_sda_oe = 1'b1;
		end
		byte_n = byte_n + 1;
	endtask

	// SCL rising, bits valid
	task sample_bit;
		if (ack_slot)
		begin
			if (reading && i_sda)
				ignore = 1'b1; // master NACK ends the read
		end
		else if (reading && byte_n > 0)
			bit_n = bit_n + 1;   // our own data bit
		else
		begin
			sh    = {sh[6:0], i_sda};
			bit_n = bit_n + 1;
		end
	endtask

	// SCL falling, SDA may change
	task drive_bit;
		if (!active || ignore)
			o_sda_oe = 1'b0;
		else if (ack_slot)
		begin
			ack_slot = 1'b0;
			o_sda_oe = reading ? !tx[7] : 1'b0; // first read bit or release
		end
		else if (bit_n == 8)
		begin
			bit_n    = 0;
			ack_slot = 1'b1;
			if (reading && byte_n > 0)
				o_sda_oe = 1'b0;  // master's ack slot
			else
				take_byte();
		end
		else if (reading && byte_n > 0)
		begin
			tx       = {tx[6:0], 1'b0};
			o_sda_oe = !tx[7];
		end
	endtask

	always @(posedge i_scl or negedge i_scl or posedge i_sda or negedge i_sda)
	begin
		if (i_scl && scl_q && sda_q && !i_sda)
		begin
			// start or repeated start
			{bit_n, byte_n} = '0;
			{reading, ignore, ack_slot, o_sda_oe} = '0;
			active = 1'b1;
		end
		else if (i_scl && scl_q && !sda_q && i_sda)
		begin
			if (active)
				stop_cnt = stop_cnt + 1;
			active   = 1'b0;
			o_sda_oe = 1'b0;
		end
		else if (i_scl && !scl_q && active && !ignore)
			sample_bit();
		else if (!i_scl && scl_q)
			drive_bit();
		scl_q = i_scl;
		sda_q = i_sda;
	end

endmodule
